//--- source/rv_decode_pkg.sv
package rv_decode_pkg;

        // data path width
        localparam int xlen = 32;

        // major opcodes, bits [6:0] of the instruction
        typedef enum logic [6:0] {
                r_type = 7'b0110011,
                i_type = 7'b0010011,
                b_type = 7'b1100011,
                jal    = 7'b1101111,
                jalr   = 7'b1100111,
                load   = 7'b0000011,
                store  = 7'b0100011,
                lui    = 7'b0110111,
                auipc  = 7'b0010111,
                system = 7'b1110011
        } opcode_e;

        // alu op class handed from main decoder to alu control
        typedef enum logic [1:0] {
                load_store = 2'b00,
                i_arith    = 2'b01,
                b_cmp      = 2'b10,
                r_arith    = 2'b11
        } alu_op_e;

        // alu function, roughly {funct7[5], funct3}
        typedef enum logic [3:0] {
                alu_add  = 4'b0000,
                alu_sll  = 4'b0001,
                alu_slt  = 4'b0010,
                alu_sltu = 4'b0011,
                alu_xor  = 4'b0100,
                alu_srl  = 4'b0101,
                alu_or   = 4'b0110,
                alu_and  = 4'b0111,
                alu_sub  = 4'b1000,
                alu_sra  = 4'b1101
        } alu_sel_e;

        // main decoder outputs
        typedef struct packed {
                logic        reg_write;
                logic        mem_write;
                // 0 alu, 1 memory, 2 csr
                logic [1:0]  mem_csr_to_reg;
                logic        branch;
                logic        alu_src;
                logic        jump;
                alu_op_e     alu_op;
                logic        lui;
                logic        auipc;
                logic        jal;
                logic        r_type;
                logic        csr_type;
        } ctrl_t;

        // payload from fetch
        typedef struct packed {
                logic [31:0]     instr;
                logic [xlen-1:0] pc;
        } fetch_t;

        // writeback port
        typedef struct packed {
                logic            valid;
                logic [4:0]      rd;
                logic [xlen-1:0] data;
        } wb_t;

        // bundle offered to execute
        typedef struct packed {
                ctrl_t           ctrl;
                alu_sel_e        alu_sel;
                logic [xlen-1:0] rs1_val;
                logic [xlen-1:0] rs2_val;
                logic [xlen-1:0] imm;
                logic [xlen-1:0] pc;
                logic [4:0]      rd;
                logic [2:0]      funct3;
        } decoded_t;

endpackage

//--- source/decode_control.sv
`timescale 1ns/1ps

module decode_control (
        input  logic [6:0]           opcode,
        output rv_decode_pkg::ctrl_t ctrl
);

        always_comb begin
                // unknown opcode falls through as a no-op bundle
                ctrl = '0;
                ctrl.alu_op = rv_decode_pkg::load_store;
                case (opcode)
                rv_decode_pkg::r_type: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op = rv_decode_pkg::r_arith;
                        ctrl.r_type = 1'b1;
                end
                rv_decode_pkg::i_type: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_src = 1'b1;
                        ctrl.alu_op = rv_decode_pkg::i_arith;
                end
                rv_decode_pkg::load: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_src = 1'b1;
                        // result comes back from memory
                        ctrl.mem_csr_to_reg = 2'd1;
                end
                rv_decode_pkg::store: begin
                        ctrl.mem_write = 1'b1;
                        ctrl.alu_src = 1'b1;
                end
                rv_decode_pkg::b_type: begin
                        // compare by subtraction in execute
                        ctrl.branch = 1'b1;
                        ctrl.alu_op = rv_decode_pkg::b_cmp;
                end
                rv_decode_pkg::jal: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_src = 1'b1;
                        ctrl.jump = 1'b1;
                        ctrl.jal = 1'b1;
                end
                rv_decode_pkg::jalr: begin
                        // target from rs1 plus imm, jal flag stays low
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_src = 1'b1;
                        ctrl.jump = 1'b1;
                end
                rv_decode_pkg::lui: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_src = 1'b1;
                        ctrl.lui = 1'b1;
                end
                rv_decode_pkg::auipc: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_src = 1'b1;
                        ctrl.auipc = 1'b1;
                end
                rv_decode_pkg::system: begin
                        // csr read value goes to rd, also covers mret
                        ctrl.reg_write = 1'b1;
                        ctrl.mem_csr_to_reg = 2'd2;
                        ctrl.csr_type = 1'b1;
                end
                default: begin
                        ctrl = '0;
                end
                endcase
        end

        // checks on the finished bundle, seen by execute and writeback
        always_comb begin
                // a store never writes back
                assert (!(ctrl.reg_write && ctrl.mem_write))
                        else $error("reg_write and mem_write both set");
                // csr ops must route the csr value to rd
                assert (!ctrl.csr_type || ctrl.mem_csr_to_reg == 2'd2)
                        else $error("csr_type without csr writeback select");
        end

endmodule

//--- source/alu_control.sv
`timescale 1ns/1ps

module alu_control (
        input  rv_decode_pkg::alu_op_e  alu_op,
        input  logic [2:0]              funct3,
        input  logic                    funct7_b5,
        output rv_decode_pkg::alu_sel_e alu_sel
);

        // sub only exists as a register-register op
        logic use_sub;

        assign use_sub = (alu_op == rv_decode_pkg::r_arith) && funct7_b5;

        always_comb begin
                alu_sel = rv_decode_pkg::alu_add;
                case (alu_op)
                // address calc for loads, stores, jumps, upper imm
                rv_decode_pkg::load_store: alu_sel = rv_decode_pkg::alu_add;
                rv_decode_pkg::b_cmp:      alu_sel = rv_decode_pkg::alu_sub;
                default: begin
                        // i_arith and r_arith share the funct3 map
                        case (funct3)
                        3'b000: alu_sel = use_sub ? rv_decode_pkg::alu_sub
                                                  : rv_decode_pkg::alu_add;
                        3'b001: alu_sel = rv_decode_pkg::alu_sll;
                        3'b010: alu_sel = rv_decode_pkg::alu_slt;
                        3'b011: alu_sel = rv_decode_pkg::alu_sltu;
                        3'b100: alu_sel = rv_decode_pkg::alu_xor;
                        // srai keeps funct7 bit 5 in the imm field
                        3'b101: alu_sel = funct7_b5 ? rv_decode_pkg::alu_sra
                                                    : rv_decode_pkg::alu_srl;
                        3'b110: alu_sel = rv_decode_pkg::alu_or;
                        default: alu_sel = rv_decode_pkg::alu_and;
                        endcase
                end
                endcase
        end

endmodule

//--- source/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
        input  logic [31:0]                     instr,
        input  rv_decode_pkg::opcode_e          opcode,
        output logic [rv_decode_pkg::xlen-1:0]  imm
);

        // every format extends from bit 31
        logic sign;

        assign sign = instr[31];

        always_comb begin
                case (opcode)
                rv_decode_pkg::i_type, rv_decode_pkg::load,
                rv_decode_pkg::jalr, rv_decode_pkg::system: begin
                        // i format, csr address lands here too
                        imm = {{(rv_decode_pkg::xlen-12){sign}}, instr[31:20]};
                end
                rv_decode_pkg::store: begin
                        // s format
                        imm = {{(rv_decode_pkg::xlen-12){sign}}, instr[31:25], instr[11:7]};
                end
                rv_decode_pkg::b_type: begin
                        // b format, half-word aligned
                        imm = {{(rv_decode_pkg::xlen-12){sign}}, instr[7], instr[30:25],
                               instr[11:8], 1'b0};
                end
                rv_decode_pkg::lui, rv_decode_pkg::auipc: begin
                        // u format, low 12 bits zero
                        imm = {{(rv_decode_pkg::xlen-32){sign}}, instr[31:12], 12'b0};
                end
                rv_decode_pkg::jal: begin
                        // j format
                        imm = {{(rv_decode_pkg::xlen-20){sign}}, instr[19:12], instr[20],
                               instr[30:21], 1'b0};
                end
                default: begin
                        imm = '0;
                end
                endcase
        end

endmodule

//--- source/register_file.sv
`timescale 1ns/1ps

module register_file #(
        parameter int num_regs = 32
) (
        input  logic                            clk,
        input  logic                            rst,
        input  logic [4:0]                      rs1,
        input  logic [4:0]                      rs2,
        input  rv_decode_pkg::wb_t              wb,
        output logic [rv_decode_pkg::xlen-1:0]  rs1_val,
        output logic [rv_decode_pkg::xlen-1:0]  rs2_val
);

        logic [rv_decode_pkg::xlen-1:0] regs [num_regs];

        // x0 and indices past num_regs never hold data
        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < num_regs; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wb.valid && wb.rd != 5'd0 && int'(wb.rd) < num_regs) begin
                        regs[wb.rd] <= wb.data;
                end
        end

        // one read port, used twice
        function automatic logic [rv_decode_pkg::xlen-1:0] read_port(input logic [4:0] idx);
                if (idx == 5'd0 || int'(idx) >= num_regs) begin
                        return '0;
                end
                // write landing on this edge wins over the stored value
                if (wb.valid && wb.rd == idx) begin
                        return wb.data;
                end
                return regs[idx];
        endfunction

        always_comb begin
                rs1_val = read_port(rs1);
                rs2_val = read_port(rs2);
        end

endmodule

//--- source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
        parameter int num_regs = 32
) (
        input  logic                    clk,
        input  logic                    rst,
        input  logic                    in_req,
        input  rv_decode_pkg::fetch_t   in_data,
        output logic                    in_ack,
        output logic                    out_req,
        output rv_decode_pkg::decoded_t out_data,
        input  logic                    out_ack,
        input  rv_decode_pkg::wb_t      wb
);

        typedef enum logic [1:0] {
                idle,
                release_in,
                offer,
                drain
        } state_e;

        state_e                         state;
        // instruction held from accept until capture
        rv_decode_pkg::fetch_t          fetch_q;
        rv_decode_pkg::ctrl_t           ctrl;
        rv_decode_pkg::alu_sel_e        alu_sel;
        logic [rv_decode_pkg::xlen-1:0] imm;
        logic [rv_decode_pkg::xlen-1:0] rs1_val;
        logic [rv_decode_pkg::xlen-1:0] rs2_val;
        rv_decode_pkg::decoded_t        decoded;

        decode_control i_decode_control (
                .opcode (fetch_q.instr[6:0]),
                .ctrl   (ctrl)
        );

        alu_control i_alu_control (
                .alu_op    (ctrl.alu_op),
                .funct3    (fetch_q.instr[14:12]),
                .funct7_b5 (fetch_q.instr[30]),
                .alu_sel   (alu_sel)
        );

        imm_gen i_imm_gen (
                .instr  (fetch_q.instr),
                .opcode (rv_decode_pkg::opcode_e'(fetch_q.instr[6:0])),
                .imm    (imm)
        );

        register_file #(
                .num_regs (num_regs)
        ) i_register_file (
                .clk     (clk),
                .rst     (rst),
                .rs1     (fetch_q.instr[19:15]),
                .rs2     (fetch_q.instr[24:20]),
                .wb      (wb),
                .rs1_val (rs1_val),
                .rs2_val (rs2_val)
        );

        // combinational bundle, sampled on the capture edge
        always_comb begin
                decoded.ctrl = ctrl;
                decoded.alu_sel = alu_sel;
                decoded.rs1_val = rs1_val;
                decoded.rs2_val = rs2_val;
                decoded.imm = imm;
                decoded.pc = fetch_q.pc;
                decoded.rd = fetch_q.instr[11:7];
                decoded.funct3 = fetch_q.instr[14:12];
        end

        // four-phase on both sides, one instruction in the stage
        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= idle;
                        in_ack <= 1'b0;
                        out_req <= 1'b0;
                        fetch_q <= '0;
                        out_data <= '0;
                end else begin
                        case (state)
                        idle: if (in_req) begin
                                fetch_q <= in_data;
                                in_ack <= 1'b1;
                                state <= release_in;
                        end
                        // fetch dropped req, capture and offer in the same edge
                        release_in: if (!in_req) begin
                                in_ack <= 1'b0;
                                out_data <= decoded;
                                out_req <= 1'b1;
                                state <= offer;
                        end
                        offer: if (out_ack) begin
                                out_req <= 1'b0;
                                state <= drain;
                        end
                        default: if (!out_ack) begin
                                state <= idle;
                        end
                        endcase
                end
        end

        // execute may sample out_data any time before it acks
        out_data_stable: assert property (@(posedge clk) disable iff (rst)
                out_req && !out_ack |=> $stable(out_data));

        // no new fetch accepted while a bundle is on offer
        no_ack_during_offer: assert property (@(posedge clk) disable iff (rst)
                !(in_ack && out_req));

endmodule

//--- include/decode_tb_tasks.svh
// first mismatch stops the run
task automatic check(input string what, input logic [191:0] exp, input logic [191:0] act);
        if (exp !== act) begin
                $display("CHECK FAILED %s %s: expected %0h actual %0h", test_name, what, exp, act);
                $display("Test failed");
                $fatal(1, "mismatch in %s", test_name);
        end
endtask

// fetch side four-phase, fwd lands on the capture edge
task automatic send_instr(input logic [31:0] instr, input logic [31:0] pc,
                          input rv_decode_pkg::wb_t fwd);
        @(posedge clk);
        in_data <= {instr, pc};
        in_req <= 1'b1;
        do begin
                @(negedge clk);
        end while (!in_ack);
        @(posedge clk);
        in_req <= 1'b0;
        wb <= fwd;
        @(negedge clk);
        // low req not yet seen by the stage
        check("in_ack before capture", 192'(1'b1), 192'(in_ack));
        check("out_req before capture", 192'(1'b0), 192'(out_req));
        @(posedge clk);
        wb <= '0;
        @(negedge clk);
        // exactly one edge from low req to offer
        check("out_req after capture", 192'(1'b1), 192'(out_req));
        check("in_ack after capture", 192'(1'b0), 192'(in_ack));
endtask

// execute side, ack held back for delay cycles
task automatic take_decoded(input int delay, output rv_decode_pkg::decoded_t got);
        while (!out_req) begin
                @(negedge clk);
        end
        got = out_data;
        repeat (delay) begin
                @(posedge clk);
                // fetch offers another word while the stage is busy
                in_data <= ~in_data;
                in_req <= 1'b1;
                @(negedge clk);
                check("out_data hold", 192'(got), 192'(out_data));
                check("out_req hold", 192'(1'b1), 192'(out_req));
                check("in_ack during offer", 192'(1'b0), 192'(in_ack));
        end
        @(posedge clk);
        in_req <= 1'b0;
        out_ack <= 1'b1;
        do begin
                @(negedge clk);
        end while (out_req);
        @(posedge clk);
        out_ack <= 1'b0;
        @(negedge clk);
endtask

task automatic decode_one(input logic [31:0] instr, input logic [31:0] pc,
                          input rv_decode_pkg::wb_t fwd, input int delay,
                          output rv_decode_pkg::decoded_t got);
        send_instr(instr, pc, fwd);
        take_decoded(delay, got);
endtask

// one writeback cycle, x0 stays zero in the model
task automatic write_reg(input logic [4:0] rd, input logic [31:0] data);
        @(posedge clk);
        wb <= {1'b1, rd, data};
        @(posedge clk);
        wb <= '0;
        if (rd != 5'd0) begin
                model[rd] = data;
        end
endtask

task automatic reset_test();
        rv_decode_pkg::decoded_t got;
        test_name = "reset";
        @(negedge clk);
        check("in_ack", 192'(1'b0), 192'(in_ack));
        check("out_req", 192'(1'b0), 192'(out_req));
        // add x3, x1, x2 on a cleared bank
        decode_one(32'h002081b3, 32'h0, '0, 0, got);
        check("rs1_val", 192'(0), 192'(got.rs1_val));
        check("rs2_val", 192'(0), 192'(got.rs2_val));
endtask

task automatic ctrl_test();
        rv_decode_pkg::decoded_t got;
        logic [6:0] ops [ctrl_count];
        logic [13:0] exp [ctrl_count];
        logic [31:0] instr;
        // isa opcodes, last one is not an opcode
        ops = '{7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111,
                7'b1100111, 7'b0110111, 7'b0010111, 7'b1110011, 7'b1111111};
        // reg_write mem_write to_reg branch alu_src jump alu_op lui auipc jal r csr
        exp = '{14'b1_0_00_0_0_0_11_0_0_0_1_0, 14'b1_0_00_0_1_0_01_0_0_0_0_0,
                14'b1_0_01_0_1_0_00_0_0_0_0_0, 14'b0_1_00_0_1_0_00_0_0_0_0_0,
                14'b0_0_00_1_0_0_10_0_0_0_0_0, 14'b1_0_00_0_1_1_00_0_0_1_0_0,
                14'b1_0_00_0_1_1_00_0_0_0_0_0, 14'b1_0_00_0_1_0_00_1_0_0_0_0,
                14'b1_0_00_0_1_0_00_0_1_0_0_0, 14'b1_0_10_0_0_0_00_0_0_0_0_1,
                14'b0_0_00_0_0_0_00_0_0_0_0_0};
        test_name = "control";
        for (int n = 0; n < ctrl_count; n++) begin
                instr = (rand_bits(25) << 7) | 32'(ops[n]);
                decode_one(instr, 32'h0, '0, 0, got);
                check("ctrl", 192'(exp[n]), 192'(got.ctrl));
        end
endtask

task automatic imm_test();
        rv_decode_pkg::decoded_t got;
        logic [6:0] ops [5];
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] exp;
        // i, s, b, u, j formats
        ops = '{7'b0010011, 7'b0100011, 7'b1100011, 7'b0110111, 7'b1101111};
        test_name = "immediate";
        for (int n = 0; n < imm_count; n++) begin
                instr = (rand_bits(25) << 7) | 32'(ops[n % 5]);
                pc = rand_bits(32);
                case (n % 5)
                0: exp = $signed(instr) >>> 20;
                1: exp = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                2: exp = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                3: exp = instr & 32'hfffff000;
                default: exp = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                instr[30:21], 1'b0};
                endcase
                decode_one(instr, pc, '0, 0, got);
                check("imm", 192'(exp), 192'(got.imm));
                check("pc", 192'(pc), 192'(got.pc));
                check("rd", 192'(instr[11:7]), 192'(got.rd));
                check("funct3", 192'(instr[14:12]), 192'(got.funct3));
        end
endtask

task automatic alu_test();
        rv_decode_pkg::decoded_t got;
        rv_decode_pkg::alu_sel_e exp;
        logic [31:0] instr;
        logic is_r;
        logic b5;
        logic [2:0] f3;
        test_name = "alu select";
        // every funct3 with both funct7 bit 5 values, i then r
        for (int n = 0; n < alu_count; n++) begin
                is_r = n[4];
                b5 = n[3];
                f3 = n[2:0];
                instr = {1'b0, b5, 5'b0, 5'd2, 5'd1, f3, 5'd3, is_r ? 7'b0110011 : 7'b0010011};
                case (f3)
                3'd0: exp = (is_r && b5) ? rv_decode_pkg::alu_sub : rv_decode_pkg::alu_add;
                3'd1: exp = rv_decode_pkg::alu_sll;
                3'd2: exp = rv_decode_pkg::alu_slt;
                3'd3: exp = rv_decode_pkg::alu_sltu;
                3'd4: exp = rv_decode_pkg::alu_xor;
                3'd5: exp = b5 ? rv_decode_pkg::alu_sra : rv_decode_pkg::alu_srl;
                3'd6: exp = rv_decode_pkg::alu_or;
                default: exp = rv_decode_pkg::alu_and;
                endcase
                decode_one(instr, 32'h0, '0, 0, got);
                check("alu_sel", 192'(exp), 192'(got.alu_sel));
        end
endtask

task automatic reg_test();
        rv_decode_pkg::decoded_t got;
        logic [31:0] data;
        logic [4:0] a;
        logic [4:0] b;
        test_name = "register file";
        // x0 gets data too and must ignore it
        for (int r = 0; r < num_regs; r++) begin
                write_reg(5'(r), rand_bits(32));
        end
        for (int n = 0; n < reg_reads; n++) begin
                a = 5'(n);
                b = 5'(31 - n);
                decode_one({7'b0, b, a, 3'b0, 5'd4, 7'b0110011}, 32'h0, '0, 0, got);
                check("rs1_val", 192'(model[a]), 192'(got.rs1_val));
                check("rs2_val", 192'(model[b]), 192'(got.rs2_val));
        end
        // write on the capture edge is forwarded
        data = rand_bits(32);
        decode_one({7'b0, 5'd0, 5'd7, 3'b0, 5'd4, 7'b0110011}, 32'h0, {1'b1, 5'd7, data}, 0, got);
        check("forwarded rs1", 192'(data), 192'(got.rs1_val));
        model[7] = data;
        // forwarding never applies to x0
        data = rand_bits(32);
        decode_one({7'b0, 5'd7, 5'd0, 3'b0, 5'd4, 7'b0110011}, 32'h0, {1'b1, 5'd0, data}, 0, got);
        check("x0 on forward", 192'(0), 192'(got.rs1_val));
        check("rs2 after forward", 192'(model[7]), 192'(got.rs2_val));
endtask

task automatic backpressure_test();
        rv_decode_pkg::decoded_t got;
        int delay;
        test_name = "back-pressure";
        for (int n = 0; n < bp_rounds; n++) begin
                delay = int'(rand_bits(4));
                // addi with a fixed imm, rs1 walks the bank
                decode_one({12'h05a, 5'(n), 3'b0, 5'(n + 1), 7'b0010011}, 32'h0, '0, delay, got);
                check("imm", 192'(32'h5a), 192'(got.imm));
                check("rs1_val", 192'(model[n]), 192'(got.rs1_val));
        end
endtask

//--- bench/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;

        localparam int num_regs = 32;
        localparam int reset_cycles = 16;
        // instructions issued by each test
        localparam int ctrl_count = 11;
        localparam int imm_count = 10;
        localparam int alu_count = 32;
        localparam int reg_reads = 16;
        localparam int bp_rounds = 8;
        localparam int num_instrs = 1 + ctrl_count + imm_count + alu_count + reg_reads + 2
                + bp_rounds;
        // two handshakes per instruction, a writeback counts as one
        localparam int num_handshakes = 2 * num_instrs + num_regs;

        logic                    clk;
        logic                    rst;
        logic                    in_req;
        rv_decode_pkg::fetch_t   in_data;
        logic                    in_ack;
        logic                    out_req;
        rv_decode_pkg::decoded_t out_data;
        logic                    out_ack;
        rv_decode_pkg::wb_t      wb;

        // random source state
        logic [31:0] lfsr_state;
        string       test_name;
        // expected contents of the register bank
        logic [31:0] model [32];

        decode_stage #(
                .num_regs (num_regs)
        ) i_decode_stage (
                .clk      (clk),
                .rst      (rst),
                .in_req   (in_req),
                .in_data  (in_data),
                .in_ack   (in_ack),
                .out_req  (out_req),
                .out_data (out_data),
                .out_ack  (out_ack),
                .wb       (wb)
        );

        // 10 ns period
        always begin
                #5 clk = ~clk;
        end

        // galois lfsr, x^32+x^22+x^2+x+1, one step per bit
        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] r;
                r = '0;
                for (int i = 0; i < n; i++) begin
                        r = {r[30:0], lfsr_state[0]};
                        if (lfsr_state[0]) begin
                                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
                        end else begin
                                lfsr_state = lfsr_state >> 1;
                        end
                end
                return r;
        endfunction

        `include "decode_tb_tasks.svh"

        // watchdog, sized from the handshake count
        initial begin
                #(num_handshakes * 200 + reset_cycles * 10);
                $display("timeout: decode stage stopped answering a handshake");
                $display("Test failed");
                $fatal(1, "watchdog expired");
        end

        initial begin
                clk = 1'b0;
                rst = 1'b1;
                in_req = 1'b0;
                in_data = '0;
                out_ack = 1'b0;
                wb = '0;
                lfsr_state = 32'h83ec;
                for (int i = 0; i < 32; i++) begin
                        model[i] = '0;
                end
                repeat (reset_cycles) @(posedge clk);
                rst <= 1'b0;
                reset_test();
                ctrl_test();
                imm_test();
                alu_test();
                reg_test();
                backpressure_test();
                $display("Test passed");
                $finish;
        end

endmodule

//--- rv_decode.f
+incdir+include
source/rv_decode_pkg.sv
source/decode_control.sv
source/alu_control.sv
source/imm_gen.sv
source/register_file.sv
source/decode_stage.sv
bench/decode_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module decode_stage_tb \
        -f rv_decode.f -o decode_stage_sim
status=$?
if [ $status -ne 0 ]; then
        echo "verilator build failed with status $status"
        exit 1
fi

output=$(./obj_dir/decode_stage_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
        exit 0
fi
echo "pass message not found in simulation output"
exit 1
